//--- include/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width.
`define XLEN 32

// First fetch address after reset.
`define RESET_VECTOR 32'h0000_0000

`define REG_COUNT 32

// Major opcodes of the supported subset.
`define OPC_LUI    7'b0110111
`define OPC_JAL    7'b1101111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011

`endif

//--- design/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  typedef logic [`XLEN-1:0] word_t;

  // One bit per byte lane.
  typedef logic [3:0] strb_t;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_t;

  // What the control FSM does with a decoded instruction.
  typedef enum logic [2:0] {
    cls_alu,
    cls_lui,
    cls_jal,
    cls_beq,
    cls_bne,
    cls_load,
    cls_store,
    cls_nop
  } instr_class_t;

endpackage

//--- design/decoder.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decoder (
  input  cpu_pkg::word_t        instr,
  output cpu_pkg::instr_class_t cls,
  output cpu_pkg::reg_idx_t     rd,
  output cpu_pkg::reg_idx_t     rs1,
  output cpu_pkg::reg_idx_t     rs2,
  output cpu_pkg::word_t        imm,
  output cpu_pkg::alu_op_t      alu_op,
  output logic                  use_imm
);
  import cpu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign rd  = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    cls     = cls_nop;
    alu_op  = alu_add;
    use_imm = 1'b0;
    imm     = imm_i;
    case (opcode)
      `OPC_LUI: begin
        cls     = cls_lui;
        alu_op  = alu_pass_b;
        use_imm = 1'b1;
        imm     = imm_u;
      end
      `OPC_JAL: begin
        cls = cls_jal;
        imm = imm_j;
      end
      `OPC_BRANCH: begin
        imm = imm_b;
        if (funct3 == 3'b000) cls = cls_beq;
        else if (funct3 == 3'b001) cls = cls_bne;
      end
      `OPC_LOAD: begin
        use_imm = 1'b1;
        if (funct3 == 3'b010) cls = cls_load;
      end
      `OPC_STORE: begin
        use_imm = 1'b1;
        imm     = imm_s;
        if (funct3 == 3'b010) cls = cls_store;
      end
      `OPC_OPIMM, `OPC_OP: begin
        use_imm = (opcode == `OPC_OPIMM);
        cls     = cls_alu;
        case (funct3)
          3'b000: alu_op = (!use_imm && funct7 == 7'b0100000) ? alu_sub : alu_add;
          3'b010: alu_op = alu_slt;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          3'b001: alu_op = alu_sll;
          3'b101: alu_op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
          default: cls = cls_nop;
        endcase
        // Shifts and register forms only accept the two defined funct7 values.
        if ((!use_imm || funct3 == 3'b001 || funct3 == 3'b101) &&
            funct7 != 7'b0000000 && funct7 != 7'b0100000) begin
          cls = cls_nop;
        end
      end
      default: cls = cls_nop;
    endcase
  end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::alu_op_t op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   y
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  // Only the low five bits of the operand take part in a shift.
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    y = a + b;
      alu_sub:    y = a - b;
      alu_slt:    y = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
      alu_xor:    y = a ^ b;
      alu_or:     y = a | b;
      alu_and:    y = a & b;
      alu_sll:    y = a << shamt;
      alu_srl:    y = a >> shamt;
      alu_sra:    y = word_t'($signed(a) >>> shamt);
      alu_pass_b: y = b;
      default:    y = a + b;
    endcase
  end

endmodule

//--- design/register.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::reg_idx_t raddr1,
  input  cpu_pkg::reg_idx_t raddr2,
  output cpu_pkg::word_t    rdata1,
  output cpu_pkg::word_t    rdata2,
  input  logic              we,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata
);
  import cpu_pkg::*;

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 is hardwired.
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/cpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu (
  input  logic             clk,
  input  logic             reset,
  output logic             imemory_valid,
  output logic             imemory_instr,
  output cpu_pkg::word_t   imemory_addr,
  output cpu_pkg::word_t   imemory_wdata,
  output cpu_pkg::strb_t   imemory_wstrb,
  input  cpu_pkg::word_t   imemory_rdata,
  input  logic             imemory_ready,
  output logic             dmemory_valid,
  output logic             dmemory_instr,
  output cpu_pkg::word_t   dmemory_addr,
  output cpu_pkg::word_t   dmemory_wdata,
  output cpu_pkg::strb_t   dmemory_wstrb,
  input  cpu_pkg::word_t   dmemory_rdata,
  input  logic             dmemory_ready
);
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_memory,
    st_writeback
  } state_t;

  state_t       state;
  word_t        pc;
  word_t        ir;
  word_t        pc_plus4;
  word_t        next_pc;
  instr_class_t cls;
  reg_idx_t     rd;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  word_t        imm;
  alu_op_t      alu_op;
  logic         use_imm;
  word_t        rs1_data;
  word_t        rs2_data;
  word_t        alu_b;
  word_t        alu_y;
  logic         branch_taken;
  logic         is_mem;
  logic         fetch_done;
  logic         rf_we;
  word_t        rf_wdata;

  decoder decoder_comp (
    .instr   (ir),
    .cls     (cls),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .imm     (imm),
    .alu_op  (alu_op),
    .use_imm (use_imm)
  );

  register register_comp (
    .clk    (clk),
    .reset  (reset),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .we     (rf_we),
    .waddr  (rd),
    .wdata  (rf_wdata)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  alu alu_comp (
    .op (alu_op),
    .a  (rs1_data),
    .b  (alu_b),
    .y  (alu_y)
  );

  assign pc_plus4     = pc + word_t'(4);
  assign branch_taken = (cls == cls_beq && rs1_data == rs2_data) ||
                        (cls == cls_bne && rs1_data != rs2_data);
  assign next_pc      = (cls == cls_jal || branch_taken) ? pc + imm : pc_plus4;
  assign is_mem       = (cls == cls_load) || (cls == cls_store);
  assign fetch_done   = (state == st_fetch) && imemory_valid && imemory_ready;

  // Register results at the end of execute, load data on the data ready edge.
  always_comb begin
    rf_we    = 1'b0;
    rf_wdata = alu_y;
    if (state == st_execute) begin
      case (cls)
        cls_alu, cls_lui: rf_we = 1'b1;
        cls_jal: begin
          rf_we    = 1'b1;
          rf_wdata = pc_plus4;
        end
        default: rf_we = 1'b0;
      endcase
    end else if (state == st_memory && dmemory_valid && dmemory_ready && cls == cls_load) begin
      rf_we    = 1'b1;
      rf_wdata = dmemory_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= st_fetch;
      pc            <= `RESET_VECTOR;
      imemory_valid <= 1'b0;
      dmemory_valid <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (!imemory_valid) begin
            imemory_valid <= 1'b1;
          end else if (imemory_ready) begin
            imemory_valid <= 1'b0;
            state         <= st_execute;
          end
        end
        st_execute: begin
          pc <= next_pc;
          if (is_mem) begin
            dmemory_valid <= 1'b1;
            state         <= st_memory;
          end else begin
            state <= st_writeback;
          end
        end
        st_memory: begin
          if (dmemory_ready) begin
            dmemory_valid <= 1'b0;
            state         <= st_writeback;
          end
        end
        default: begin
          imemory_valid <= 1'b1;
          state         <= st_fetch;
        end
      endcase
    end
  end

  // Instruction and data request payload.
  always_ff @(posedge clk) begin
    if (fetch_done) begin
      ir <= imemory_rdata;
    end
    if (state == st_execute && is_mem) begin
      dmemory_addr  <= alu_y;
      dmemory_wdata <= rs2_data;
      dmemory_wstrb <= (cls == cls_store) ? '1 : '0;
    end
  end

  assign imemory_addr  = pc;
  assign imemory_wdata = '0;
  assign imemory_wstrb = '0;
  assign imemory_instr = 1'b1;
  assign dmemory_instr = 1'b0;

endmodule

//--- sim/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int period_ns = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

//--- sim/cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
  input logic           clk,
  input logic           reset,
  input logic           imemory_valid,
  input cpu_pkg::word_t imemory_addr,
  input cpu_pkg::strb_t imemory_wstrb,
  input logic           imemory_ready,
  input logic           dmemory_valid,
  input cpu_pkg::word_t dmemory_addr,
  input cpu_pkg::strb_t dmemory_wstrb,
  input logic           dmemory_ready
);

  // A pending request keeps its payload until the ready edge.
  imem_hold: assert property (@(posedge clk) disable iff (reset)
    imemory_valid && !imemory_ready |=>
      imemory_valid && $stable(imemory_addr) && $stable(imemory_wstrb))
    else $error("imemory request dropped or changed before ready");

  dmem_hold: assert property (@(posedge clk) disable iff (reset)
    dmemory_valid && !dmemory_ready |=>
      dmemory_valid && $stable(dmemory_addr) && $stable(dmemory_wstrb))
    else $error("dmemory request dropped or changed before ready");

  idle_in_reset: assert property (@(posedge clk) reset |=> !imemory_valid && !dmemory_valid)
    else $error("memory valid high during reset");

  no_instr_write: assert property (@(posedge clk) imemory_wstrb == '0)
    else $error("write strobe on the instruction port");

  one_port_at_a_time: assert property (@(posedge clk) disable iff (reset)
    !(imemory_valid && dmemory_valid))
    else $error("both memory ports requested at once");

endmodule

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int clk_period_ns = 40;
  localparam int reset_cycles  = 5;
  localparam int pair_count    = 120;
  localparam int last_index    = 2 * pair_count;
  localparam int prog_len      = last_index + 1;
  localparam int watchdog_ns   = (64 * prog_len + reset_cycles + 2) * clk_period_ns;

  logic  clk;
  logic  reset;
  logic  imemory_valid;
  logic  imemory_instr;
  word_t imemory_addr;
  word_t imemory_wdata;
  strb_t imemory_wstrb;
  word_t imemory_rdata;
  logic  imemory_ready;
  logic  dmemory_valid;
  logic  dmemory_instr;
  word_t dmemory_addr;
  word_t dmemory_wdata;
  strb_t dmemory_wstrb;
  word_t dmemory_rdata;
  logic  dmemory_ready;

  word_t imem [256];
  word_t gen_imm [256];
  word_t gen_target [256];
  word_t dmem [64];
  word_t model_dmem [64];
  word_t model_regs [`REG_COUNT];
  word_t model_pc;
  int    checks;
  int    errors;

  clock_gen #(.period_ns(clk_period_ns)) clock_gen_i (.clk(clk));

  cpu cpu_i (
    .clk           (clk),
    .reset         (reset),
    .imemory_valid (imemory_valid),
    .imemory_instr (imemory_instr),
    .imemory_addr  (imemory_addr),
    .imemory_wdata (imemory_wdata),
    .imemory_wstrb (imemory_wstrb),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_instr (dmemory_instr),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  bind cpu cpu_checker cpu_checker_i (
    .clk           (clk),
    .reset         (reset),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_wstrb (imemory_wstrb),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_ready (dmemory_ready)
  );

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OPC_STORE};
  endfunction

  function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  function automatic word_t u_type(input logic [19:0] upper, input reg_idx_t rd);
    return {upper, rd, `OPC_LUI};
  endfunction

  // Random pairs of one instruction and a store of its result, then a self loop.
  task automatic build_program();
    int          kind;
    int          tgt;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    for (int i = 0; i < 256; i++) begin
      imem[i]       = i_type(12'(i), 5'd0, 3'd0, 5'd0, `OPC_OPIMM);
      gen_imm[i]    = '0;
      gen_target[i] = '0;
    end
    for (int i = 0; i < last_index; i += 2) begin
      kind = $urandom_range(5, 0);
      rd   = reg_idx_t'($urandom_range(7, 0));
      rs1  = reg_idx_t'($urandom_range(7, 0));
      rs2  = reg_idx_t'($urandom_range(7, 0));
      f3   = 3'($urandom_range(7, 0));
      if (f3 == 3'd3) begin
        f3 = 3'd0;
      end
      f7 = 7'h00;
      if ((f3 == 3'd5 || (kind == 1 && f3 == 3'd0)) && $urandom_range(1, 0) == 1) begin
        f7 = 7'h20;
      end
      tgt = i + $urandom_range(7, 1);
      if (tgt > last_index) begin
        tgt = last_index;
      end
      case (kind)
        0: begin
          imm12 = (f3 == 3'd1 || f3 == 3'd5) ? {f7, 5'($urandom)} : 12'($urandom);
          imem[i]    = i_type(imm12, rs1, f3, rd, `OPC_OPIMM);
          gen_imm[i] = {{20{imm12[11]}}, imm12};
        end
        1: imem[i] = r_type(f7, rs2, rs1, f3, rd);
        2: begin
          gen_imm[i] = {20'($urandom), 12'h000};
          imem[i]    = u_type(gen_imm[i][31:12], rd);
        end
        3: begin
          imm12 = {4'h0, 6'($urandom), 2'b00};
          imem[i]    = i_type(imm12, 5'd0, 3'b010, rd, `OPC_LOAD);
          gen_imm[i] = 32'(imm12);
        end
        4: begin
          imem[i]       = b_type(13'((tgt - i) * 4), rs2, rs1, {2'b00, f3[0]});
          gen_target[i] = word_t'(tgt * 4);
        end
        default: begin
          imem[i]       = j_type(21'((tgt - i) * 4), rd);
          gen_target[i] = word_t'(tgt * 4);
        end
      endcase
      imm12          = {4'h0, 6'($urandom), 2'b00};
      imem[i + 1]    = s_type(imm12, (kind == 4) ? rs2 : rd, 5'd0);
      gen_imm[i + 1] = 32'(imm12);
    end
    imem[last_index]       = j_type(21'd0, 5'd0);
    gen_target[last_index] = word_t'(last_index * 4);
  endtask

  function automatic word_t alu_result(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Executes the instruction at model_pc.
  task automatic model_step(output logic is_store, output word_t st_addr,
                            output word_t st_data);
    word_t ins;
    word_t imm;
    word_t a;
    word_t b;
    word_t ea;
    word_t res;
    word_t nxt;
    logic  wr;
    ins      = imem[model_pc[9:2]];
    imm      = gen_imm[model_pc[9:2]];
    a        = model_regs[ins[19:15]];
    b        = model_regs[ins[24:20]];
    ea       = a + imm;
    nxt      = model_pc + 32'd4;
    res      = '0;
    wr       = 1'b0;
    is_store = 1'b0;
    st_addr  = '0;
    st_data  = '0;
    case (ins[6:0])
      `OPC_LUI: begin
        res = imm;
        wr  = 1'b1;
      end
      `OPC_JAL: begin
        res = nxt;
        wr  = 1'b1;
        nxt = gen_target[model_pc[9:2]];
      end
      `OPC_BRANCH: begin
        if (ins[12] ? (a != b) : (a == b)) begin
          nxt = gen_target[model_pc[9:2]];
        end
      end
      `OPC_LOAD: begin
        res = model_dmem[ea[7:2]];
        wr  = 1'b1;
      end
      `OPC_STORE: begin
        is_store              = 1'b1;
        st_addr               = ea;
        st_data               = b;
        model_dmem[ea[7:2]]   = b;
      end
      `OPC_OPIMM: begin
        res = alu_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm);
        wr  = 1'b1;
      end
      `OPC_OP: begin
        res = alu_result(ins[14:12], ins[30], a, b);
        wr  = 1'b1;
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      model_regs[ins[11:7]] = res;
    end
    model_pc = nxt;
  endtask

  task automatic wait_fetch();
    @(negedge clk);
    while (!(imemory_valid && imemory_ready)) @(negedge clk);
  endtask

  task automatic wait_data_transfer();
    @(negedge clk);
    while (!(dmemory_valid && dmemory_ready)) @(negedge clk);
  endtask

  task automatic check_fetch(input word_t expected);
    checks++;
    if (imemory_addr !== expected) begin
      errors++;
      $display("[FAIL] %0t imemory_addr expected %08h actual %08h",
               $time, expected, imemory_addr);
    end
    // The instruction port marks every request as a fetch.
    if (imemory_instr !== 1'b1) begin
      errors++;
      $display("[FAIL] %0t imemory_instr expected 1 actual %b",
               $time, imemory_instr);
    end
  endtask

  task automatic check_store(input word_t exp_addr, input word_t exp_data);
    checks++;
    if (dmemory_addr !== exp_addr) begin
      errors++;
      $display("[FAIL] %0t dmemory_addr expected %08h actual %08h",
               $time, exp_addr, dmemory_addr);
    end
    if (dmemory_wdata !== exp_data) begin
      errors++;
      $display("[FAIL] %0t dmemory_wdata expected %08h actual %08h",
               $time, exp_data, dmemory_wdata);
    end
    // A word store enables all four byte lanes.
    if (dmemory_wstrb !== 4'b1111) begin
      errors++;
      $display("[FAIL] %0t dmemory_wstrb expected f actual %h",
               $time, dmemory_wstrb);
    end
    if (dmemory_instr !== 1'b0) begin
      errors++;
      $display("[FAIL] %0t dmemory_instr expected 0 actual %b",
               $time, dmemory_instr);
    end
  endtask

  task automatic report_counts();
    $display("Summary: %0d checks, %0d errors", checks, errors);
  endtask

  // Instruction memory with 0 to 3 wait cycles.
  initial begin
    imemory_ready = 1'b0;
    imemory_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && imemory_valid) begin
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk);
          #1;
        end
        imemory_rdata = imem[imemory_addr[9:2]];
        imemory_ready = 1'b1;
        @(posedge clk);
        #1;
        imemory_ready = 1'b0;
      end
    end
  end

  // Data memory, written lane by lane.
  initial begin
    dmemory_ready = 1'b0;
    dmemory_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      if (!reset && dmemory_valid) begin
        repeat ($urandom_range(3, 0)) begin
          @(posedge clk);
          #1;
        end
        dmemory_rdata = dmem[dmemory_addr[7:2]];
        for (int lane = 0; lane < 4; lane++) begin
          if (dmemory_wstrb[lane]) begin
            dmem[dmemory_addr[7:2]][lane*8 +: 8] = dmemory_wdata[lane*8 +: 8];
          end
        end
        dmemory_ready = 1'b1;
        @(posedge clk);
        #1;
        dmemory_ready = 1'b0;
      end
    end
  end

  initial begin : main
    logic  is_store;
    logic  looping;
    word_t st_addr;
    word_t st_data;
    word_t pc_before;
    checks  = 0;
    errors  = 0;
    looping = 1'b0;
    reset   = 1'b1;
    void'($urandom(46));
    build_program();
    for (int k = 0; k < 64; k++) begin
      dmem[k]       = $urandom();
      model_dmem[k] = dmem[k];
    end
    for (int k = 0; k < `REG_COUNT; k++) begin
      model_regs[k] = '0;
    end
    model_pc = `RESET_VECTOR;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    while (!looping) begin
      wait_fetch();
      check_fetch(model_pc);
      pc_before = model_pc;
      model_step(is_store, st_addr, st_data);
      if (is_store) begin
        wait_data_transfer();
        check_store(st_addr, st_data);
      end
      looping = (model_pc == pc_before);
    end
    // The final jump fetches itself again.
    wait_fetch();
    check_fetch(model_pc);
    report_counts();
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    errors++;
    $display("Timeout after %0d ns, the program did not reach its final loop", watchdog_ns);
    report_counts();
    $display("Test failed");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
design/cpu_pkg.sv
design/decoder.sv
design/alu.sv
design/register.sv
design/cpu.sv
sim/clock_gen.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

//--- Makefile
TOP = cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Test completed successfully" > /dev/null

clean:
	rm -rf obj_dir
